//--- verilog.f
+incdir+bench
design/dbg_pkg.sv
design/jtag_dtm.sv
design/dm_sba.sv
design/sba_sram.sv
design/dbg_top.sv
bench/tb_dbg_top.sv

//--- bench/jtag_drv.svh
/* TAP driver tasks, included inside the testbench module.
   Expects clk_sys, tms_i, tdi_i, tdo_o and a timeouts counter in the including scope.
   Every scan starts and ends in Run-Test/Idle. */
`ifndef JTAG_DRV_SVH
`define JTAG_DRV_SVH

localparam int DMI_W      = DMI_ABITS + DMI_DBITS + 2;
localparam int SBBUSY_BIT = 21;
localparam int POLL_LIMIT = 50;

// One TCK cycle, TDO sampled on the falling edge
task automatic clock_tap(input logic tms, input logic tdi, output logic tdo);
   @(posedge clk_sys);
   tms_i <= tms;
   tdi_i <= tdi;
   @(negedge clk_sys);
   tdo = tdo_o;
endtask

// Five TMS ones reach Test-Logic-Reset from any state
task automatic reset_tap();
   logic unused;
   repeat (5) clock_tap(1'b1, 1'b0, unused);
   clock_tap(1'b0, 1'b0, unused);
endtask

task automatic shift_ir(input logic [4:0] code);
   logic unused;
   int   i;
   clock_tap(1'b1, 1'b0, unused);
   clock_tap(1'b1, 1'b0, unused);
   clock_tap(1'b0, 1'b0, unused);
   clock_tap(1'b0, 1'b0, unused);
   // LSB first, TMS high on the last bit
   for (i = 0; i < 5; i++) begin
      clock_tap(i == 4, code[i], unused);
   end
   clock_tap(1'b1, 1'b0, unused);
   clock_tap(1'b0, 1'b0, unused);
endtask

task automatic shift_dr(input int nbits, input logic [DMI_W-1:0] din,
                        output logic [DMI_W-1:0] dout);
   logic bit_out;
   int   i;
   dout = '0;
   clock_tap(1'b1, 1'b0, bit_out);
   clock_tap(1'b0, 1'b0, bit_out);
   clock_tap(1'b0, 1'b0, bit_out);
   for (i = 0; i < nbits; i++) begin
      clock_tap(i == nbits - 1, din[i], bit_out);
      dout[i] = bit_out;
   end
   // Exit1-DR, then Update-DR back to idle
   clock_tap(1'b1, 1'b0, bit_out);
   clock_tap(1'b0, 1'b0, bit_out);
endtask

// Request scan, then a nop scan that captures the response
task automatic scan_dmi(input logic [1:0] op, input logic [DMI_ABITS-1:0] addr,
                        input logic [31:0] wdata, output logic [1:0] rsp,
                        output logic [31:0] rdata);
   logic [DMI_W-1:0] dout;
   shift_ir(IR_DMI);
   shift_dr(DMI_W, {addr, wdata, op}, dout);
   shift_dr(DMI_W, {addr, 32'd0, DMI_OP_NOP}, dout);
   rsp   = dout[1:0];
   rdata = dout[DMI_DBITS+1:2];
endtask

task automatic write_dmi(input logic [DMI_ABITS-1:0] addr, input logic [31:0] data,
                         output logic [1:0] rsp);
   logic [31:0] unused;
   scan_dmi(DMI_OP_WRITE, addr, data, rsp, unused);
endtask

task automatic read_dmi(input logic [DMI_ABITS-1:0] addr, output logic [31:0] rdata,
                        output logic [1:0] rsp);
   scan_dmi(DMI_OP_READ, addr, 32'd0, rsp, rdata);
endtask

task automatic wait_sba_idle(input int step);
   logic [31:0] rdata;
   logic [1:0]  rsp;
   logic        busy;
   int          polls;
   busy  = 1'b1;
   polls = 0;
   while (busy && polls < POLL_LIMIT) begin
      read_dmi(DM_SBCS, rdata, rsp);
      busy = (rdata[SBBUSY_BIT] !== 1'b0);
      polls++;
   end
   if (busy) begin
      $display("sbbusy still set after %0d polls following step %0d, giving up",
               POLL_LIMIT, step);
      timeouts++;
   end
endtask

`endif

//--- bench/tb_dbg_top.sv
/* Testbench for the JTAG debug path with TCK running at clk_sys.
   Memory words are random from a fixed seed and known before the table is built. */
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_top
   import dbg_pkg::*;
();

   localparam logic [31:0] IDCODE     = 32'h1000_5a6b;
   localparam int          MEM_WORDS  = 256;
   localparam logic [31:0] START_ADDR = 32'h0000_0100;
   localparam int          MAX_STEPS  = 48;

   // SBCS field masks, standard layout
   localparam logic [31:0] ERR_MASK  = 32'h0000_7000;
   localparam logic [31:0] IDLE_MASK = 32'h0060_7000;

   typedef struct packed {
      logic [1:0]           op;
      logic [DMI_ABITS-1:0] addr;
      logic [31:0]          wdata;
      logic [31:0]          exp;
      logic [31:0]          care;
      logic                 poll;
   } step_t;

   logic        clk_sys;
   logic        rst_i;
   logic        tms_i;
   logic        tdi_i;
   wire         tdo_o;
   step_t       steps [MAX_STEPS];
   logic [31:0] words [8];
   int          step_count;
   int          errors;
   int          timeouts;

   dbg_top #(
      .IDCODE_VAL (IDCODE),
      .MEM_WORDS  (MEM_WORDS)
   ) dut_i (
      .clk_sys (clk_sys),
      .rst_i   (rst_i),
      .tms_i   (tms_i),
      .tdi_i   (tdi_i),
      .tdo_o   (tdo_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s, got %h, expected %h",
                  $time, what, actual, expected);
         errors++;
      end
   endtask

   `include "jtag_drv.svh"

   task automatic add_step(input logic [1:0] op, input logic [DMI_ABITS-1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic [31:0] care, input logic poll);
      steps[step_count] = {op, addr, wdata, exp, care, poll};
      step_count++;
   endtask

   // Standard SBCS write word
   function automatic logic [31:0] make_sbcs(input logic rdonaddr, input logic [2:0] access,
                                             input logic autoinc, input logic rdondata,
                                             input logic [2:0] errclr);
      logic [31:0] w;
      w          = '0;
      w[20]      = rdonaddr;
      w[19:17]   = access;
      w[16]      = autoinc;
      w[15]      = rdondata;
      w[14:12]   = errclr;
      return w;
   endfunction

   task automatic build_table();
      int i;
      add_step(DMI_OP_WRITE, DM_DATA0, 32'hc0de_5a17, '0, '0, 1'b0);
      add_step(DMI_OP_READ, DM_DATA0, '0, 32'hc0de_5a17, 32'hffff_ffff, 1'b0);
      add_step(DMI_OP_READ, DM_DMSTATUS, '0, 32'h0000_0002, 32'h0000_000f, 1'b0);
      // sbversion 1, sbasize 32, only the 32-bit access flag
      add_step(DMI_OP_READ, DM_SBCS, '0, 32'h2000_0404, 32'he000_0fff, 1'b0);
      // Preload with autoincrement
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 3'd0), '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, START_ADDR, '0, '0, 1'b0);
      for (i = 0; i < 8; i++) begin
         add_step(DMI_OP_WRITE, DM_SBDATA0, words[i], '0, '0, 1'b1);
      end
      add_step(DMI_OP_READ, DM_SBADDRESS0, '0, START_ADDR + 32'd32, 32'hffff_ffff, 1'b0);
      // Read back with read-on-address and read-on-data
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b1, 3'd2, 1'b1, 1'b1, 3'd0), '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, START_ADDR, '0, '0, 1'b1);
      for (i = 0; i < 7; i++) begin
         add_step(DMI_OP_READ, DM_SBDATA0, '0, words[i], 32'hffff_ffff, 1'b1);
      end
      // Last read fetches nothing more
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b1, 3'd2, 1'b1, 1'b0, 3'd0), '0, '0, 1'b0);
      add_step(DMI_OP_READ, DM_SBDATA0, '0, words[7], 32'hffff_ffff, 1'b0);
      add_step(DMI_OP_READ, DM_SBADDRESS0, '0, START_ADDR + 32'd32, 32'hffff_ffff, 1'b0);
      // 16-bit access size is refused
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b0, 3'd1, 1'b0, 1'b0, 3'd0), '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, START_ADDR, '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBDATA0, ~words[0], '0, '0, 1'b0);
      add_step(DMI_OP_READ, DM_SBCS, '0, 32'h0000_4000, ERR_MASK, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b1, 3'd2, 1'b0, 1'b0, 3'd7), '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, START_ADDR, '0, '0, 1'b1);
      add_step(DMI_OP_READ, DM_SBDATA0, '0, words[0], 32'hffff_ffff, 1'b0);
      add_step(DMI_OP_READ, DM_SBCS, '0, 32'h0000_0000, ERR_MASK, 1'b0);
      // First address past the SRAM
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, 32'(MEM_WORDS * 4), '0, '0, 1'b0);
      add_step(DMI_OP_READ, DM_SBCS, '0, 32'h0000_2000, ERR_MASK, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBCS, make_sbcs(1'b1, 3'd2, 1'b0, 1'b0, 3'd7), '0, '0, 1'b0);
      add_step(DMI_OP_WRITE, DM_SBADDRESS0, START_ADDR + 32'd4, '0, '0, 1'b1);
      add_step(DMI_OP_READ, DM_SBDATA0, '0, words[1], 32'hffff_ffff, 1'b0);
      add_step(DMI_OP_READ, DM_SBCS, '0, 32'h0000_0000, IDLE_MASK, 1'b0);
   endtask

   initial begin
      logic [DMI_W-1:0] dout;
      logic [31:0]      rdata;
      logic [1:0]       rsp;
      int               s;
      rst_i      = 1'b1;
      tms_i      = 1'b1;
      tdi_i      = 1'b0;
      errors     = 0;
      timeouts   = 0;
      step_count = 0;
      void'($urandom(32'hcfa7));
      for (s = 0; s < 8; s++) begin
         words[s] = $urandom;
      end
      build_table();
      repeat (5) @(posedge clk_sys);
      rst_i <= 1'b0;

      // IDCODE is selected after a TAP reset
      reset_tap();
      shift_dr(32, '0, dout);
      check_value(dout[31:0], IDCODE, "IDCODE scan");
      shift_ir(IR_DTMCS);
      shift_dr(32, '0, dout);
      check_value(dout[31:0] & 32'h0000_03ff, 32'h0000_0071, "DTMCS abits and version");

      for (s = 0; s < step_count; s++) begin
         if (steps[s].op == DMI_OP_WRITE) begin
            write_dmi(steps[s].addr, steps[s].wdata, rsp);
         end else begin
            read_dmi(steps[s].addr, rdata, rsp);
            check_value(rdata & steps[s].care, steps[s].exp & steps[s].care,
                        $sformatf("step %0d read of DMI 0x%02h", s, steps[s].addr));
         end
         check_value(32'(rsp), 32'(DMI_RSP_OK), $sformatf("step %0d response op", s));
         if (steps[s].poll) begin
            wait_sba_idle(s);
         end
      end

      $display("Summary: %0d errors, %0d poll timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/dbg_top.sv
/* JTAG debug path: DTM, debug module with SBA, and a word SRAM.
   TCK is clk_sys; MEM_WORDS should be a power of two. */
`timescale 1ns/1ps
`default_nettype none

module dbg_top import dbg_pkg::*; #(
   parameter logic [31:0] IDCODE_VAL = 32'h0000_0001,
   parameter int          MEM_WORDS  = 1024
) (
   input  wire  clk_sys,
   input  wire  rst_i,
   input  wire  tms_i,
   input  wire  tdi_i,
   output logic tdo_o
);

   // DMI between DTM and DM
   logic                 dmi_req;
   logic [1:0]           dmi_op;
   logic [DMI_ABITS-1:0] dmi_addr;
   logic [DMI_DBITS-1:0] dmi_wdata;
   logic                 dmi_rsp;
   logic [DMI_DBITS-1:0] dmi_rdata;

   // System bus to the SRAM
   logic                         mem_req;
   logic                         mem_we;
   logic [$clog2(MEM_WORDS)-1:0] mem_addr;
   logic [31:0]                  mem_wdata;
   logic                         mem_rvalid;
   logic [31:0]                  mem_rdata;

   jtag_dtm #(
      .IDCODE_VAL (IDCODE_VAL)
   ) dtm_i (
      .clk_sys     (clk_sys),
      .rst_i       (rst_i),
      .tms_i       (tms_i),
      .tdi_i       (tdi_i),
      .tdo_o       (tdo_o),
      .dmi_req_o   (dmi_req),
      .dmi_op_o    (dmi_op),
      .dmi_addr_o  (dmi_addr),
      .dmi_wdata_o (dmi_wdata),
      .dmi_rsp_i   (dmi_rsp),
      .dmi_rdata_i (dmi_rdata)
   );

   dm_sba #(
      .MEM_WORDS (MEM_WORDS)
   ) dm_i (
      .clk_sys      (clk_sys),
      .rst_i        (rst_i),
      .dmi_req_i    (dmi_req),
      .dmi_op_i     (dmi_op),
      .dmi_addr_i   (dmi_addr),
      .dmi_wdata_i  (dmi_wdata),
      .dmi_rsp_o    (dmi_rsp),
      .dmi_rdata_o  (dmi_rdata),
      .mem_req_o    (mem_req),
      .mem_we_o     (mem_we),
      .mem_addr_o   (mem_addr),
      .mem_wdata_o  (mem_wdata),
      .mem_rvalid_i (mem_rvalid),
      .mem_rdata_i  (mem_rdata)
   );

   sba_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) sram_i (
      .clk_sys      (clk_sys),
      .rst_i        (rst_i),
      .mem_req_i    (mem_req),
      .mem_we_i     (mem_we),
      .mem_addr_i   (mem_addr),
      .mem_wdata_i  (mem_wdata),
      .mem_rvalid_o (mem_rvalid),
      .mem_rdata_o  (mem_rdata)
   );

endmodule

`default_nettype wire

//--- design/sba_sram.sv
/* Word-addressed single-port SRAM, contents are not initialised.
   Reads return data one cycle after the strobe, writes return nothing. */
`timescale 1ns/1ps
`default_nettype none

module sba_sram #(
   parameter int MEM_WORDS = 1024
) (
   input  wire                          clk_sys,
   input  wire                          rst_i,
   input  wire                          mem_req_i,
   input  wire                          mem_we_i,
   input  wire  [$clog2(MEM_WORDS)-1:0] mem_addr_i,
   input  wire  [31:0]                  mem_wdata_i,
   output logic                         mem_rvalid_o,
   output logic [31:0]                  mem_rdata_o
);

   logic [31:0] mem_q [MEM_WORDS];

   always_ff @(posedge clk_sys) begin
      if (mem_req_i && mem_we_i) begin
         mem_q[mem_addr_i] <= mem_wdata_i;
      end
   end

   // Read port
   always_ff @(posedge clk_sys) begin
      if (mem_req_i && !mem_we_i) begin
         mem_rdata_o <= mem_q[mem_addr_i];
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         mem_rvalid_o <= 1'b0;
      end else begin
         mem_rvalid_o <= mem_req_i && !mem_we_i;
      end
   end

endmodule

`default_nettype wire

//--- design/dm_sba.sv
/* Debug module with data0, dmactive and 32-bit system bus access only.
   Every DMI request is answered one cycle later and an SBA access takes 2 cycles. */
`timescale 1ns/1ps
`default_nettype none

module dm_sba import dbg_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input  wire                          clk_sys,
   input  wire                          rst_i,
   input  wire                          dmi_req_i,
   input  wire  [1:0]                   dmi_op_i,
   input  wire  [DMI_ABITS-1:0]         dmi_addr_i,
   input  wire  [DMI_DBITS-1:0]         dmi_wdata_i,
   output logic                         dmi_rsp_o,
   output logic [DMI_DBITS-1:0]         dmi_rdata_o,
   output logic                         mem_req_o,
   output logic                         mem_we_o,
   output logic [$clog2(MEM_WORDS)-1:0] mem_addr_o,
   output logic [31:0]                  mem_wdata_o,
   input  wire                          mem_rvalid_i,
   input  wire  [31:0]                  mem_rdata_i
);

   localparam int          AW        = $clog2(MEM_WORDS);
   localparam int unsigned MEM_BYTES = MEM_WORDS * 4;

   localparam logic [1:0]
      SBA_IDLE  = 2'd0,
      SBA_ISSUE = 2'd1,
      SBA_WAIT  = 2'd2;

   logic [1:0]           op_q;
   logic [DMI_ABITS-1:0] addr_q;
   dmi_word_u            wr_word;
   dmi_word_u            rd_sbcs;
   logic [31:0]          data0_q;
   logic                 dmactive_q;
   logic                 sbbusyerror_q;
   logic                 sbreadonaddr_q;
   logic [2:0]           sbaccess_q;
   logic                 sbautoinc_q;
   logic                 sbreadondata_q;
   logic [2:0]           sberror_q;
   logic [31:0]          sbaddress0_q;
   logic [31:0]          sbdata0_q;
   logic [1:0]           sba_state_q;
   logic                 bus_we_q;
   logic                 wr_en;
   logic                 rd_en;
   logic                 sba_busy;
   logic                 err_hold;
   logic                 acc_req;
   logic                 acc_we;
   logic [31:0]          acc_addr;
   logic                 bad_addr;

   assign wr_en    = dmi_rsp_o && (op_q == DMI_OP_WRITE);
   assign rd_en    = dmi_rsp_o && (op_q == DMI_OP_READ);
   assign sba_busy = (sba_state_q != SBA_IDLE);
   assign err_hold = sbbusyerror_q || (sberror_q != SBERR_NONE);

   // Bus access triggers are all seen on the response cycle
   assign acc_we  = wr_en && (addr_q == DM_SBDATA0);
   assign acc_req = acc_we ||
                    (wr_en && addr_q == DM_SBADDRESS0 && sbreadonaddr_q) ||
                    (rd_en && addr_q == DM_SBDATA0 && sbreadondata_q);

   // A new sbaddress0 is checked before it lands in the register
   assign acc_addr = (wr_en && addr_q == DM_SBADDRESS0) ? wr_word.raw : sbaddress0_q;
   assign bad_addr = (acc_addr[1:0] != 2'b00) || (acc_addr >= MEM_BYTES);

   always_comb begin
      rd_sbcs.raw                 = '0;
      rd_sbcs.sbcs.sbversion      = 3'd1;
      rd_sbcs.sbcs.sbbusyerror    = sbbusyerror_q;
      rd_sbcs.sbcs.sbbusy         = sba_busy;
      rd_sbcs.sbcs.sbreadonaddr   = sbreadonaddr_q;
      rd_sbcs.sbcs.sbaccess       = sbaccess_q;
      rd_sbcs.sbcs.sbautoincrement = sbautoinc_q;
      rd_sbcs.sbcs.sbreadondata   = sbreadondata_q;
      rd_sbcs.sbcs.sberror        = sberror_q;
      rd_sbcs.sbcs.sbasize        = 7'd32;
      rd_sbcs.sbcs.sbaccess_sizes = 5'b00100;
   end

   always_comb begin
      dmi_rdata_o = '0;
      if (op_q == DMI_OP_READ) begin
         case (addr_q)
            DM_DATA0:      dmi_rdata_o = data0_q;
            DM_DMCONTROL:  dmi_rdata_o = {31'd0, dmactive_q};
            DM_DMSTATUS:   dmi_rdata_o = 32'd2;
            DM_SBCS:       dmi_rdata_o = rd_sbcs.raw;
            DM_SBADDRESS0: dmi_rdata_o = sbaddress0_q;
            // Bypass read data arriving this cycle
            DM_SBDATA0:    dmi_rdata_o = mem_rvalid_i ? mem_rdata_i : sbdata0_q;
            default:       dmi_rdata_o = '0;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         dmi_rsp_o      <= 1'b0;
         data0_q        <= '0;
         dmactive_q     <= 1'b0;
         sbbusyerror_q  <= 1'b0;
         sbreadonaddr_q <= 1'b0;
         sbaccess_q     <= 3'd0;
         sbautoinc_q    <= 1'b0;
         sbreadondata_q <= 1'b0;
         sberror_q      <= SBERR_NONE;
         sbaddress0_q   <= '0;
         sbdata0_q      <= '0;
         sba_state_q    <= SBA_IDLE;
         mem_req_o      <= 1'b0;
      end else begin
         dmi_rsp_o <= dmi_req_i;
         mem_req_o <= 1'b0;
         case (sba_state_q)
            SBA_ISSUE: begin
               mem_req_o   <= 1'b1;
               sba_state_q <= SBA_WAIT;
            end
            SBA_WAIT: begin
               sba_state_q <= SBA_IDLE;
               if (sbautoinc_q) begin
                  sbaddress0_q <= sbaddress0_q + 32'd4;
               end
            end
            default: begin
               sba_state_q <= SBA_IDLE;
            end
         endcase
         if (mem_rvalid_i) begin
            sbdata0_q <= mem_rdata_i;
         end
         // DMI writes override bus updates on the same edge
         if (wr_en) begin
            case (addr_q)
               DM_DATA0:      data0_q <= wr_word.raw;
               DM_DMCONTROL:  dmactive_q <= wr_word.raw[0];
               DM_SBCS: begin
                  sbbusyerror_q  <= sbbusyerror_q & ~wr_word.sbcs.sbbusyerror;
                  sberror_q      <= sberror_q & ~wr_word.sbcs.sberror;
                  sbreadonaddr_q <= wr_word.sbcs.sbreadonaddr;
                  sbaccess_q     <= wr_word.sbcs.sbaccess;
                  sbautoinc_q    <= wr_word.sbcs.sbautoincrement;
                  sbreadondata_q <= wr_word.sbcs.sbreadondata;
               end
               DM_SBADDRESS0: sbaddress0_q <= wr_word.raw;
               DM_SBDATA0:    sbdata0_q <= wr_word.raw;
               default: ;
            endcase
         end
         if (acc_req && sba_busy) begin
            sbbusyerror_q <= 1'b1;
         end else if (acc_req && !err_hold) begin
            if (sbaccess_q != 3'd2) begin
               sberror_q <= SBERR_BADSIZE;
            end else if (bad_addr) begin
               sberror_q <= SBERR_BADADDR;
            end else begin
               sba_state_q <= SBA_ISSUE;
            end
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_req_i) begin
         op_q        <= dmi_op_i;
         addr_q      <= dmi_addr_i;
         wr_word.raw <= dmi_wdata_i;
      end
      if (acc_req) begin
         bus_we_q <= acc_we;
      end
      if (sba_state_q == SBA_ISSUE) begin
         mem_we_o    <= bus_we_q;
         mem_addr_o  <= sbaddress0_q[AW+1:2];
         mem_wdata_o <= sbdata0_q;
      end
   end

endmodule

`default_nettype wire

//--- design/jtag_dtm.sv
/* JTAG DTM with TCK tied to clk_sys, so the TAP moves one state per clock.
   A DMI request made while one is pending is dropped and sets sticky busy status. */
`timescale 1ns/1ps
`default_nettype none

module jtag_dtm import dbg_pkg::*; #(
   parameter logic [31:0] IDCODE_VAL = 32'h0000_0001
) (
   input  wire                  clk_sys,
   input  wire                  rst_i,
   input  wire                  tms_i,
   input  wire                  tdi_i,
   output logic                 tdo_o,
   output logic                 dmi_req_o,
   output logic [1:0]           dmi_op_o,
   output logic [DMI_ABITS-1:0] dmi_addr_o,
   output logic [DMI_DBITS-1:0] dmi_wdata_o,
   input  wire                  dmi_rsp_i,
   input  wire  [DMI_DBITS-1:0] dmi_rdata_i
);

   localparam int DR_W = DMI_ABITS + DMI_DBITS + 2;

   localparam logic [3:0]
      S_TLR    = 4'h0,
      S_RTI    = 4'h1,
      S_SEL_DR = 4'h2,
      S_CAP_DR = 4'h3,
      S_SH_DR  = 4'h4,
      S_EX1_DR = 4'h5,
      S_PAU_DR = 4'h6,
      S_EX2_DR = 4'h7,
      S_UPD_DR = 4'h8,
      S_SEL_IR = 4'h9,
      S_CAP_IR = 4'hA,
      S_SH_IR  = 4'hB,
      S_EX1_IR = 4'hC,
      S_PAU_IR = 4'hD,
      S_EX2_IR = 4'hE,
      S_UPD_IR = 4'hF;

   logic [3:0]           tap_state_q;
   logic [3:0]           tap_state_d;
   logic [4:0]           ir_q;
   logic [4:0]           ir_shift_q;
   logic [DR_W-1:0]      dr_q;
   logic [DMI_DBITS-1:0] rsp_data_q;
   logic                 rsp_pending_q;
   logic                 busy_sticky_q;
   logic [1:0]           upd_op;
   logic                 dmi_update;
   logic                 dmi_issue;

   // Standard TAP transitions
   always_comb begin
      case (tap_state_q)
         S_TLR:    tap_state_d = tms_i ? S_TLR    : S_RTI;
         S_RTI:    tap_state_d = tms_i ? S_SEL_DR : S_RTI;
         S_SEL_DR: tap_state_d = tms_i ? S_SEL_IR : S_CAP_DR;
         S_CAP_DR: tap_state_d = tms_i ? S_EX1_DR : S_SH_DR;
         S_SH_DR:  tap_state_d = tms_i ? S_EX1_DR : S_SH_DR;
         S_EX1_DR: tap_state_d = tms_i ? S_UPD_DR : S_PAU_DR;
         S_PAU_DR: tap_state_d = tms_i ? S_EX2_DR : S_PAU_DR;
         S_EX2_DR: tap_state_d = tms_i ? S_UPD_DR : S_SH_DR;
         S_UPD_DR: tap_state_d = tms_i ? S_SEL_DR : S_RTI;
         S_SEL_IR: tap_state_d = tms_i ? S_TLR    : S_CAP_IR;
         S_CAP_IR: tap_state_d = tms_i ? S_EX1_IR : S_SH_IR;
         S_SH_IR:  tap_state_d = tms_i ? S_EX1_IR : S_SH_IR;
         S_EX1_IR: tap_state_d = tms_i ? S_UPD_IR : S_PAU_IR;
         S_PAU_IR: tap_state_d = tms_i ? S_EX2_IR : S_PAU_IR;
         S_EX2_IR: tap_state_d = tms_i ? S_UPD_IR : S_SH_IR;
         default:  tap_state_d = tms_i ? S_SEL_DR : S_RTI;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         tap_state_q <= S_TLR;
      end else begin
         tap_state_q <= tap_state_d;
      end
   end

   // Test-Logic-Reset also selects IDCODE
   always_ff @(posedge clk_sys) begin
      if (rst_i || tap_state_q == S_TLR) begin
         ir_q <= IR_IDCODE;
      end else if (tap_state_q == S_UPD_IR) begin
         ir_q <= ir_shift_q;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (tap_state_q == S_CAP_IR) begin
         ir_shift_q <= 5'b00001;
      end else if (tap_state_q == S_SH_IR) begin
         ir_shift_q <= {tdi_i, ir_shift_q[4:1]};
      end
   end

   // One shift register serves every DR and its length depends on IR
   always_ff @(posedge clk_sys) begin
      if (tap_state_q == S_CAP_DR) begin
         case (ir_q)
            IR_IDCODE: dr_q <= {9'd0, IDCODE_VAL};
            IR_DTMCS:  dr_q <= {29'd0, {2{busy_sticky_q}}, 6'(DMI_ABITS), 4'd1};
            IR_DMI:    dr_q <= {dmi_addr_o, rsp_data_q,
                                busy_sticky_q ? DMI_RSP_BUSY : DMI_RSP_OK};
            default:   dr_q <= '0;
         endcase
      end else if (tap_state_q == S_SH_DR) begin
         case (ir_q)
            IR_DMI:              dr_q <= {tdi_i, dr_q[DR_W-1:1]};
            IR_IDCODE, IR_DTMCS: dr_q <= {9'd0, tdi_i, dr_q[31:1]};
            default:             dr_q <= {40'd0, tdi_i};
         endcase
      end
   end

   assign tdo_o = (tap_state_q == S_SH_IR) ? ir_shift_q[0] : dr_q[0];

   assign upd_op     = dr_q[1:0];
   assign dmi_update = (tap_state_q == S_UPD_DR) && (ir_q == IR_DMI);
   assign dmi_issue  = dmi_update && !rsp_pending_q && !busy_sticky_q &&
                       (upd_op == DMI_OP_READ || upd_op == DMI_OP_WRITE);

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         dmi_req_o     <= 1'b0;
         rsp_pending_q <= 1'b0;
         busy_sticky_q <= 1'b0;
      end else begin
         dmi_req_o <= dmi_issue;
         if (dmi_issue) begin
            rsp_pending_q <= 1'b1;
         end else if (dmi_rsp_i) begin
            rsp_pending_q <= 1'b0;
         end
         // An overlapping request is reported as busy until dmireset
         if (dmi_update && upd_op != DMI_OP_NOP && rsp_pending_q) begin
            busy_sticky_q <= 1'b1;
         end
         // dmireset or dmihardreset
         if (tap_state_q == S_UPD_DR && ir_q == IR_DTMCS && (dr_q[16] || dr_q[17])) begin
            busy_sticky_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_issue) begin
         dmi_op_o    <= upd_op;
         dmi_addr_o  <= dr_q[DR_W-1:DMI_DBITS+2];
         dmi_wdata_o <= dr_q[DMI_DBITS+1:2];
      end
      if (dmi_rsp_i) begin
         rsp_data_q <= dmi_rdata_i;
      end
   end

endmodule

`default_nettype wire

//--- design/dbg_pkg.sv
/* Shared widths, DMI addresses and codes for the debug path.
   SBCS layout follows the RISC-V debug spec, only 32-bit accesses are reported. */
`default_nettype none

package dbg_pkg;

   // DMI geometry
   localparam int DMI_ABITS = 7;
   localparam int DMI_DBITS = 32;

   // Request ops in, response ops out
   localparam logic [1:0] DMI_OP_NOP   = 2'd0;
   localparam logic [1:0] DMI_OP_READ  = 2'd1;
   localparam logic [1:0] DMI_OP_WRITE = 2'd2;
   localparam logic [1:0] DMI_RSP_OK   = 2'd0;
   localparam logic [1:0] DMI_RSP_BUSY = 2'd3;

   // DM register map
   localparam logic [DMI_ABITS-1:0] DM_DATA0      = 7'h04;
   localparam logic [DMI_ABITS-1:0] DM_DMCONTROL  = 7'h10;
   localparam logic [DMI_ABITS-1:0] DM_DMSTATUS   = 7'h11;
   localparam logic [DMI_ABITS-1:0] DM_SBCS       = 7'h38;
   localparam logic [DMI_ABITS-1:0] DM_SBADDRESS0 = 7'h39;
   localparam logic [DMI_ABITS-1:0] DM_SBDATA0    = 7'h3C;

   localparam logic [2:0] SBERR_NONE    = 3'd0;
   localparam logic [2:0] SBERR_BADADDR = 3'd2;
   localparam logic [2:0] SBERR_BADSIZE = 3'd4;

   // TAP instructions, any other code selects BYPASS
   localparam logic [4:0] IR_IDCODE = 5'h01;
   localparam logic [4:0] IR_DTMCS  = 5'h10;
   localparam logic [4:0] IR_DMI    = 5'h11;

   typedef struct packed {
      logic [2:0] sbversion;
      logic [5:0] rsvd;
      logic       sbbusyerror;
      logic       sbbusy;
      logic       sbreadonaddr;
      logic [2:0] sbaccess;
      logic       sbautoincrement;
      logic       sbreadondata;
      logic [2:0] sberror;
      logic [6:0] sbasize;
      logic [4:0] sbaccess_sizes;
   } sbcs_t;

   // One DMI data word, seen raw or as SBCS fields
   typedef union packed {
      logic [DMI_DBITS-1:0] raw;
      sbcs_t                sbcs;
   } dmi_word_u;

endpackage

`default_nettype wire
